// ==== rtl/vchess_ctrl_pkg.sv ====
package vchess_ctrl_pkg;

   localparam int AXI_ADDR_WIDTH = 40;
   localparam int AXI_DATA_WIDTH = 32;
   localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
   localparam int REG_INDEX_WIDTH = 14;
   localparam int REG_INDEX_LSB = 2; // Word aligned registers

   localparam int SIDE_WIDTH = 32;
   localparam int BOARD_WORDS = 8;
   localparam int BOARD_WIDTH = SIDE_WIDTH * BOARD_WORDS;
   localparam int BOARD_SEL_WIDTH = $clog2(BOARD_WORDS);

   typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
   typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
   typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
   typedef logic [1:0] axi_resp_t;
   typedef logic [BOARD_WIDTH-1:0] board_t;
   typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;

   localparam reg_index_t REG_CONTROL = 14'd0;
   localparam reg_index_t REG_MOVE_INDEX = 14'd1;
   localparam reg_index_t REG_POSITION = 14'd2;
   localparam reg_index_t REG_HALF_MOVE = 14'd3;
   localparam reg_index_t REG_CAPTURE = 14'd4;
   localparam reg_index_t REG_BOARD_BASE = 14'd8;
   localparam reg_index_t REG_EVAL = 14'd134;
   localparam reg_index_t REG_MOVE_COUNT = 14'd135;
   localparam reg_index_t REG_INITIAL_EVAL = 14'd136;
   localparam reg_index_t REG_HALF_MOVE_IN = 14'd138;

   // Data bit positions of the control register
   localparam int CTRL_NEW_BOARD_VALID_BIT = 0;
   localparam int CTRL_CLEAR_MOVES_BIT = 1;
   localparam int CTRL_USE_RANDOM_BIT = 30;
   localparam int CTRL_SOFT_RESET_BIT = 31;

   typedef struct packed {
      logic soft_reset;
      logic use_random_bit;
      logic clear_moves;
      logic new_board_valid;
   } control_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   localparam int POSITION_WIDTH = $bits(position_t);

   typedef struct packed {
      logic mate;
      logic stalemate;
      logic thrice_rep;
      logic fifty_move;
      logic insufficient_material;
      logic board_check;
   } root_status_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
   } wdata_beat_t;

   function automatic reg_index_t addr_to_index(axi_addr_t addr);
      return addr[REG_INDEX_LSB +: REG_INDEX_WIDTH];
   endfunction

   function automatic logic is_board_index(reg_index_t index);
      return (index >= REG_BOARD_BASE) && (index < REG_BOARD_BASE + BOARD_WORDS);
   endfunction

endpackage

// ==== rtl/reg_write_if.sv ====
`timescale 1ns/1ps

interface reg_write_if;
   import vchess_ctrl_pkg::*;

   logic       valid; // One cycle per committed write
   reg_index_t index;
   axi_data_t  data;
   axi_strb_t  strb;

   modport commit
     (
      output valid,
      output index,
      output data,
      output strb
      );

   modport bank
     (
      input valid,
      input index,
      input data,
      input strb
      );

endinterface

// ==== rtl/axi_channel_slot.sv ====
`timescale 1ns/1ps

module axi_channel_slot #
  (
   parameter type payload_t = logic
   )
   (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,

    input  logic     take,
    output logic     full,
    output payload_t payload
    );

   logic accept;

   assign in_ready = !full; // Ready while empty
   assign accept = in_valid && in_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         full <= 1'b0;
      end
      else if (accept)
      begin
         full <= 1'b1;
      end
      else if (take)
      begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         payload <= in_payload;
      end
   end

endmodule

// ==== rtl/axi_write_commit.sv ====
`timescale 1ns/1ps

module axi_write_commit
  (
   input  logic                        clk,
   input  logic                        reset,

   input  logic                        aw_full,
   input  vchess_ctrl_pkg::axi_addr_t  aw_addr,
   input  logic                        w_full,
   input  vchess_ctrl_pkg::wdata_beat_t w_beat,
   output logic                        take,

   output logic                        bvalid,
   input  logic                        bready,
   output vchess_ctrl_pkg::axi_resp_t  bresp,

   reg_write_if.commit                 wr
   );

   import vchess_ctrl_pkg::*;

   logic commit;

   // Both beats held and no response pending
   assign commit = aw_full && w_full && !bvalid;
   assign take = commit;

   assign wr.valid = commit;
   assign wr.index = addr_to_index(aw_addr);
   assign wr.data = w_beat.data;
   assign wr.strb = w_beat.strb;

   assign bresp = RESP_OKAY; // No error responses

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bvalid <= 1'b0;
      end
      else if (commit)
      begin
         bvalid <= 1'b1;
      end
      else if (bready)
      begin
         bvalid <= 1'b0;
      end
   end

endmodule

// ==== rtl/control_reg_bank.sv ====
`timescale 1ns/1ps

module control_reg_bank #
  (
   parameter int MAX_POSITIONS_LOG2 = 8,
   parameter int HALF_MOVE_WIDTH = 8
   )
   (
    input  logic                            clk,
    input  logic                            reset,

    reg_write_if.bank                       wr,

    output vchess_ctrl_pkg::control_t       control,
    output logic [MAX_POSITIONS_LOG2-1:0]   move_index,
    output vchess_ctrl_pkg::position_t      position,
    output logic [HALF_MOVE_WIDTH-1:0]      half_move,
    output logic                            capture_moves,
    output vchess_ctrl_pkg::board_t         new_board
    );

   import vchess_ctrl_pkg::*;

   logic [BOARD_SEL_WIDTH-1:0] board_sel;
   axi_data_t                  cur_word;
   axi_data_t                  merged;

   assign board_sel = wr.index[BOARD_SEL_WIDTH-1:0]; // Base is word aligned

   // Current image of the addressed register
   always_comb
   begin
      cur_word = '0;
      case (wr.index)
         REG_CONTROL:
         begin
            cur_word[CTRL_NEW_BOARD_VALID_BIT] = control.new_board_valid;
            cur_word[CTRL_CLEAR_MOVES_BIT] = control.clear_moves;
            cur_word[CTRL_USE_RANDOM_BIT] = control.use_random_bit;
            cur_word[CTRL_SOFT_RESET_BIT] = control.soft_reset;
         end
         REG_MOVE_INDEX: cur_word = axi_data_t'(move_index);
         REG_POSITION:   cur_word = axi_data_t'(position);
         REG_HALF_MOVE:  cur_word = axi_data_t'(half_move);
         REG_CAPTURE:    cur_word = axi_data_t'(capture_moves);
         default:
         begin
            if (is_board_index(wr.index))
            begin
               cur_word = new_board[board_sel * SIDE_WIDTH +: SIDE_WIDTH];
            end
         end
      endcase
      for (int lane = 0; lane < AXI_STRB_WIDTH; lane++)
      begin
         merged[lane * 8 +: 8] = wr.strb[lane] ? wr.data[lane * 8 +: 8] : cur_word[lane * 8 +: 8];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control <= '0;
         move_index <= '0;
         position <= '0;
         half_move <= '0;
         capture_moves <= 1'b0;
         new_board <= '0;
      end
      else if (wr.valid)
      begin
         case (wr.index)
            REG_CONTROL:
            begin
               control.new_board_valid <= merged[CTRL_NEW_BOARD_VALID_BIT];
               control.clear_moves <= merged[CTRL_CLEAR_MOVES_BIT];
               control.use_random_bit <= merged[CTRL_USE_RANDOM_BIT];
               control.soft_reset <= merged[CTRL_SOFT_RESET_BIT];
            end
            REG_MOVE_INDEX: move_index <= merged[MAX_POSITIONS_LOG2-1:0];
            REG_POSITION:   position <= position_t'(merged[POSITION_WIDTH-1:0]);
            REG_HALF_MOVE:  half_move <= merged[HALF_MOVE_WIDTH-1:0];
            REG_CAPTURE:    capture_moves <= merged[0];
            default:
            begin
               if (is_board_index(wr.index))
               begin
                  new_board[board_sel * SIDE_WIDTH +: SIDE_WIDTH] <= merged;
               end
            end
         endcase
      end
   end

endmodule

// ==== rtl/status_read_port.sv ====
`timescale 1ns/1ps

module status_read_port #
  (
   parameter int MAX_POSITIONS_LOG2 = 8,
   parameter int HALF_MOVE_WIDTH = 8,
   parameter int EVAL_WIDTH = 24
   )
   (
    input  logic                             clk,
    input  logic                             reset,

    input  vchess_ctrl_pkg::axi_addr_t       araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output vchess_ctrl_pkg::axi_data_t       rdata,
    output vchess_ctrl_pkg::axi_resp_t       rresp,
    output logic                             rvalid,
    input  logic                             rready,

    input  vchess_ctrl_pkg::control_t        control,
    input  logic [MAX_POSITIONS_LOG2-1:0]    move_index,
    input  vchess_ctrl_pkg::position_t       position,
    input  logic [HALF_MOVE_WIDTH-1:0]       half_move,
    input  logic                             capture_moves,
    input  vchess_ctrl_pkg::board_t          new_board,

    input  logic                             am_idle,
    input  logic                             am_moves_ready,
    input  logic                             am_move_ready,
    input  vchess_ctrl_pkg::root_status_t    root_status,
    input  logic [MAX_POSITIONS_LOG2-1:0]    am_move_count,
    input  logic signed [EVAL_WIDTH-1:0]     am_eval,
    input  logic signed [EVAL_WIDTH-1:0]     initial_eval,
    input  logic [HALF_MOVE_WIDTH-1:0]       am_half_move
    );

   import vchess_ctrl_pkg::*;

   reg_index_t                 rd_index;
   logic [BOARD_SEL_WIDTH-1:0] board_sel;
   axi_data_t                  read_word;

   assign rd_index = addr_to_index(araddr);
   assign board_sel = rd_index[BOARD_SEL_WIDTH-1:0];
   assign arready = !rvalid; // One read in flight
   assign rresp = RESP_OKAY;

   always_comb
   begin
      read_word = '0;
      case (rd_index)
         REG_CONTROL:
         begin
            read_word[CTRL_NEW_BOARD_VALID_BIT] = control.new_board_valid;
            read_word[CTRL_CLEAR_MOVES_BIT] = control.clear_moves;
            read_word[2] = am_moves_ready;
            read_word[3] = am_move_ready;
            read_word[4] = root_status.stalemate;
            read_word[5] = root_status.mate;
            read_word[6] = root_status.thrice_rep;
            read_word[7] = am_idle;
            read_word[8] = root_status.fifty_move;
            read_word[9] = root_status.insufficient_material;
            read_word[10] = root_status.board_check;
            read_word[CTRL_USE_RANDOM_BIT] = control.use_random_bit;
            read_word[CTRL_SOFT_RESET_BIT] = control.soft_reset;
         end
         REG_MOVE_INDEX:   read_word = axi_data_t'(move_index);
         REG_POSITION:     read_word = axi_data_t'(position);
         REG_HALF_MOVE:    read_word = axi_data_t'(half_move);
         REG_CAPTURE:      read_word = axi_data_t'(capture_moves);
         REG_EVAL:         read_word = {{(AXI_DATA_WIDTH - EVAL_WIDTH){am_eval[EVAL_WIDTH-1]}}, am_eval};
         REG_MOVE_COUNT:   read_word = axi_data_t'(am_move_count);
         REG_INITIAL_EVAL:
            read_word = {{(AXI_DATA_WIDTH - EVAL_WIDTH){initial_eval[EVAL_WIDTH-1]}}, initial_eval};
         REG_HALF_MOVE_IN: read_word = axi_data_t'(am_half_move);
         default:
         begin
            if (is_board_index(rd_index))
            begin
               read_word = new_board[board_sel * SIDE_WIDTH +: SIDE_WIDTH];
            end
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rvalid <= 1'b0;
      end
      else if (arvalid && arready)
      begin
         rvalid <= 1'b1;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
      begin
         rdata <= read_word; // Sampled at acceptance
      end
   end

endmodule

// ==== rtl/ctrl_regs_top.sv ====
`timescale 1ns/1ps

module ctrl_regs_top #
  (
   parameter int MAX_POSITIONS_LOG2 = 8,
   parameter int HALF_MOVE_WIDTH = 8,
   parameter int EVAL_WIDTH = 24
   )
   (
    input  logic                            clk,
    input  logic                            reset,

    input  vchess_ctrl_pkg::axi_addr_t      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  vchess_ctrl_pkg::axi_data_t      wdata,
    input  vchess_ctrl_pkg::axi_strb_t      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic                            bvalid,
    input  logic                            bready,
    output vchess_ctrl_pkg::axi_resp_t      bresp,
    input  vchess_ctrl_pkg::axi_addr_t      araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output vchess_ctrl_pkg::axi_data_t      rdata,
    output vchess_ctrl_pkg::axi_resp_t      rresp,
    output logic                            rvalid,
    input  logic                            rready,

    input  logic                            am_idle,
    input  logic                            am_moves_ready,
    input  logic                            am_move_ready,
    input  logic [MAX_POSITIONS_LOG2-1:0]   am_move_count,
    input  logic signed [EVAL_WIDTH-1:0]    am_eval, // Indexed move
    input  logic [HALF_MOVE_WIDTH-1:0]      am_half_move,
    input  logic                            initial_mate,
    input  logic                            initial_stalemate,
    input  logic                            initial_thrice_rep,
    input  logic                            initial_fifty_move,
    input  logic                            initial_insufficient_material,
    input  logic                            initial_board_check,
    input  logic signed [EVAL_WIDTH-1:0]    initial_eval, // Root position

    output logic                            new_board_valid,
    output logic                            clear_moves,
    output logic                            use_random_bit,
    output logic                            soft_reset,
    output logic [MAX_POSITIONS_LOG2-1:0]   move_index,
    output logic                            white_to_move,
    output logic [3:0]                      castle_mask,
    output logic [3:0]                      en_passant_col,
    output logic [HALF_MOVE_WIDTH-1:0]      half_move,
    output logic                            capture_moves,
    output vchess_ctrl_pkg::board_t         new_board
    );

   import vchess_ctrl_pkg::*;

   logic         aw_full;
   axi_addr_t    aw_addr;
   logic         w_full;
   wdata_beat_t  w_beat_in;
   wdata_beat_t  w_beat;
   logic         take;
   control_t     control;
   position_t    position;
   root_status_t root_status;

   reg_write_if wr_if ();

   assign w_beat_in = '{data: wdata, strb: wstrb};

   assign root_status = '{mate: initial_mate, stalemate: initial_stalemate,
                          thrice_rep: initial_thrice_rep, fifty_move: initial_fifty_move,
                          insufficient_material: initial_insufficient_material,
                          board_check: initial_board_check};

   assign new_board_valid = control.new_board_valid;
   assign clear_moves = control.clear_moves;
   assign use_random_bit = control.use_random_bit;
   assign soft_reset = control.soft_reset; // Register only, drives the engine
   assign white_to_move = position.white_to_move;
   assign castle_mask = position.castle_mask;
   assign en_passant_col = position.en_passant_col;

   axi_channel_slot #(.payload_t(axi_addr_t)) aw_slot
     (.clk(clk), .reset(reset), .in_valid(awvalid), .in_ready(awready), .in_payload(awaddr),
      .take(take), .full(aw_full), .payload(aw_addr));

   axi_channel_slot #(.payload_t(wdata_beat_t)) w_slot
     (.clk(clk), .reset(reset), .in_valid(wvalid), .in_ready(wready), .in_payload(w_beat_in),
      .take(take), .full(w_full), .payload(w_beat));

   axi_write_commit write_commit
     (.clk(clk), .reset(reset), .aw_full(aw_full), .aw_addr(aw_addr), .w_full(w_full),
      .w_beat(w_beat), .take(take), .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .wr(wr_if.commit));

   control_reg_bank #(.MAX_POSITIONS_LOG2(MAX_POSITIONS_LOG2),
                      .HALF_MOVE_WIDTH(HALF_MOVE_WIDTH)) reg_bank
     (.clk(clk), .reset(reset), .wr(wr_if.bank), .control(control), .move_index(move_index),
      .position(position), .half_move(half_move), .capture_moves(capture_moves),
      .new_board(new_board));

   status_read_port #(.MAX_POSITIONS_LOG2(MAX_POSITIONS_LOG2),
                      .HALF_MOVE_WIDTH(HALF_MOVE_WIDTH),
                      .EVAL_WIDTH(EVAL_WIDTH)) read_port
     (.clk(clk), .reset(reset), .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .control(control), .move_index(move_index), .position(position), .half_move(half_move),
      .capture_moves(capture_moves), .new_board(new_board), .am_idle(am_idle),
      .am_moves_ready(am_moves_ready), .am_move_ready(am_move_ready),
      .root_status(root_status), .am_move_count(am_move_count), .am_eval(am_eval),
      .initial_eval(initial_eval), .am_half_move(am_half_move));

endmodule

// ==== verification/ctrl_regs_model.svh ====
`ifndef CTRL_REGS_MODEL_SVH
`define CTRL_REGS_MODEL_SVH

// Host view of the writable registers
control_t             img_control;
logic [MOVE_BITS-1:0] img_move_index;
position_t            img_position;
logic [HALF_BITS-1:0] img_half_move;
logic                 img_capture;
board_t               img_board;

function automatic void clear_image();
   img_control = '0;
   img_move_index = '0;
   img_position = '0;
   img_half_move = '0;
   img_capture = 1'b0;
   img_board = '0;
endfunction

// Board word number, or -1 outside the board window
function automatic int board_word(reg_index_t idx);
   if ((idx >= REG_BOARD_BASE) && (idx <= REG_BOARD_BASE + 14'd7))
      return int'(idx - REG_BOARD_BASE);
   return -1;
endfunction

function automatic axi_data_t image_word(reg_index_t idx);
   axi_data_t word;
   int sel;
   word = '0;
   sel = board_word(idx);
   case (idx)
      REG_CONTROL:
      begin
         word[0] = img_control.new_board_valid;
         word[1] = img_control.clear_moves;
         word[30] = img_control.use_random_bit;
         word[31] = img_control.soft_reset;
      end
      REG_MOVE_INDEX:
         word = axi_data_t'(img_move_index);
      REG_POSITION:
      begin
         word[8] = img_position.white_to_move;
         word[7:4] = img_position.castle_mask;
         word[3:0] = img_position.en_passant_col;
      end
      REG_HALF_MOVE:
         word = axi_data_t'(img_half_move);
      REG_CAPTURE:
         word[0] = img_capture;
      default:
      begin
         if (sel >= 0)
            word = img_board[sel * 32 +: 32];
      end
   endcase
   return word;
endfunction

function automatic void apply_write(reg_index_t idx, axi_data_t data, axi_strb_t strb);
   axi_data_t word;
   int sel;
   word = image_word(idx);
   sel = board_word(idx);
   for (int lane = 0; lane < 4; lane++)
   begin
      if (strb[lane])
         word[lane * 8 +: 8] = data[lane * 8 +: 8]; // Unstrobed lanes keep old bytes
   end
   case (idx)
      REG_CONTROL:
      begin
         img_control.new_board_valid = word[0];
         img_control.clear_moves = word[1];
         img_control.use_random_bit = word[30];
         img_control.soft_reset = word[31];
      end
      REG_MOVE_INDEX:
         img_move_index = word[MOVE_BITS-1:0];
      REG_POSITION:
      begin
         img_position.white_to_move = word[8];
         img_position.castle_mask = word[7:4];
         img_position.en_passant_col = word[3:0];
      end
      REG_HALF_MOVE:
         img_half_move = word[HALF_BITS-1:0];
      REG_CAPTURE:
         img_capture = word[0];
      default:
      begin
         if (sel >= 0)
            img_board[sel * 32 +: 32] = word;
      end
   endcase
endfunction

function automatic axi_data_t expected_read(reg_index_t idx);
   axi_data_t word;
   case (idx)
      REG_CONTROL:
      begin
         word = image_word(idx);
         word[2] = am_moves_ready;
         word[3] = am_move_ready;
         word[4] = initial_stalemate;
         word[5] = initial_mate;
         word[6] = initial_thrice_rep;
         word[7] = am_idle;
         word[8] = initial_fifty_move;
         word[9] = initial_insufficient_material;
         word[10] = initial_board_check;
      end
      REG_EVAL:
         word = axi_data_t'(int'(am_eval));
      REG_MOVE_COUNT:
         word = axi_data_t'(am_move_count);
      REG_INITIAL_EVAL:
         word = axi_data_t'(int'(initial_eval));
      REG_HALF_MOVE_IN:
         word = axi_data_t'(am_half_move);
      default:
         word = image_word(idx); // Unknown indices give zero
   endcase
   return word;
endfunction

`endif

// ==== verification/tb_ctrl_regs.sv ====
`timescale 1ns/1ps

module tb_ctrl_regs;
   import vchess_ctrl_pkg::*;

   localparam int MOVE_BITS = 8;
   localparam int HALF_BITS = 8;
   localparam int EVAL_BITS = 24;
   localparam int NUM_RANDOM = 80;
   localparam int NUM_STALLS = 4;
   // Reset reads, write and read pairs, random ops, status reads, stalled pairs
   localparam int NUM_TXNS = 13 + 26 + NUM_RANDOM + 20 + 2 * NUM_STALLS;
   localparam int TIMEOUT_CYCLES = 200 * NUM_TXNS + 100;

   logic clk;
   logic reset;
   axi_addr_t awaddr;
   axi_addr_t araddr;
   axi_data_t wdata;
   axi_data_t rdata;
   axi_strb_t wstrb;
   axi_resp_t bresp;
   axi_resp_t rresp;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic am_idle, am_moves_ready, am_move_ready;
   logic [MOVE_BITS-1:0] am_move_count;
   logic [HALF_BITS-1:0] am_half_move;
   logic signed [EVAL_BITS-1:0] am_eval;
   logic signed [EVAL_BITS-1:0] initial_eval;
   logic initial_mate, initial_stalemate, initial_thrice_rep;
   logic initial_fifty_move, initial_insufficient_material, initial_board_check;
   logic new_board_valid, clear_moves, use_random_bit, soft_reset;
   logic [MOVE_BITS-1:0] move_index;
   logic white_to_move;
   logic [3:0] castle_mask;
   logic [3:0] en_passant_col;
   logic [HALF_BITS-1:0] half_move;
   logic capture_moves;
   board_t new_board;

   logic [31:0] lcg_state = 32'h752f_3038;
   int cycles = 0;

   `include "ctrl_regs_model.svh"

   ctrl_regs_top dut (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("ERROR: the run hangs, no progress after %0d cycles", cycles);
         stop_run();
      end
   end

   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(int n);
      return int'((rand32() >> 8) % n); // Low LCG bits are weak
   endfunction

   // Indices 0 to 4, then the board words 8 to 15
   function automatic reg_index_t write_index(int n);
      return (n < 5) ? reg_index_t'(n) : reg_index_t'(n + 3);
   endfunction

   function automatic reg_index_t status_index(int n);
      case (n)
         0: return REG_CONTROL;
         1: return REG_EVAL;
         2: return REG_MOVE_COUNT;
         3: return REG_INITIAL_EVAL;
         default: return REG_HALF_MOVE_IN;
      endcase
   endfunction

   function automatic reg_index_t pick_unknown();
      case (rand_below(4))
         0: return reg_index_t'(5 + rand_below(3));
         1: return reg_index_t'(16 + rand_below(118));
         2: return 14'd137;
         default: return reg_index_t'(139 + rand_below(16000));
      endcase
   endfunction

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic expect_true(logic cond, string what);
      if (!cond)
      begin
         $display("ERROR at %0t: %s", $time, what);
         stop_run();
      end
   endtask

   task automatic check_data(axi_data_t got, axi_data_t exp, string name);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_board(board_t got, board_t exp, string name);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_position(position_t got, position_t exp, string name);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_control(control_t got, control_t exp, string name);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_resp(axi_resp_t got, axi_resp_t exp, string name);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_outputs();
      check_control({soft_reset, use_random_bit, clear_moves, new_board_valid}, img_control,
                    "control outputs");
      check_data(axi_data_t'(move_index), axi_data_t'(img_move_index), "move_index");
      check_position({white_to_move, castle_mask, en_passant_col}, img_position,
                     "position outputs");
      check_data(axi_data_t'(half_move), axi_data_t'(img_half_move), "half_move");
      check_data(axi_data_t'(capture_moves), axi_data_t'(img_capture), "capture_moves");
      check_board(new_board, img_board, "new_board");
   endtask

   // AW and W beats in either order with independent gaps
   task automatic put_write(reg_index_t idx, axi_data_t data, axi_strb_t strb);
      int aw_gap;
      int w_gap;
      aw_gap = rand_below(4);
      w_gap = rand_below(4);
      fork
         begin
            repeat (aw_gap) @(posedge clk);
            @(posedge clk);
            awaddr <= axi_addr_t'({idx, 2'b00});
            awvalid <= 1'b1;
            @(negedge clk);
            while (!awready)
               @(negedge clk);
            @(posedge clk);
            awvalid <= 1'b0;
         end
         begin
            repeat (w_gap) @(posedge clk);
            @(posedge clk);
            wdata <= data;
            wstrb <= strb;
            wvalid <= 1'b1;
            @(negedge clk);
            while (!wready)
               @(negedge clk);
            @(posedge clk);
            wvalid <= 1'b0;
         end
      join
   endtask

   task automatic take_response();
      int hold;
      hold = rand_below(4);
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      check_resp(bresp, RESP_OKAY, "bresp");
      repeat (hold)
      begin
         @(negedge clk);
         expect_true(bvalid, "bvalid dropped while bready was low");
         check_resp(bresp, RESP_OKAY, "bresp");
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
      @(negedge clk);
      expect_true(!bvalid, "bvalid still high after the response was taken");
   endtask

   task automatic write_reg(reg_index_t idx, axi_data_t data, axi_strb_t strb);
      put_write(idx, data, strb);
      apply_write(idx, data, strb);
      take_response();
      expect_true(awready && wready, "write slots not empty after the response");
      check_outputs();
   endtask

   // Engine inputs only move while no read is in flight
   task automatic shuffle_engine();
      logic [31:0] flags;
      logic [31:0] counts;
      logic [31:0] eval_a;
      logic [31:0] eval_b;
      flags = rand32();
      counts = rand32();
      eval_a = rand32();
      eval_b = rand32();
      @(posedge clk);
      am_idle <= flags[31];
      am_moves_ready <= flags[30];
      am_move_ready <= flags[29];
      initial_mate <= flags[28];
      initial_stalemate <= flags[27];
      initial_thrice_rep <= flags[26];
      initial_fifty_move <= flags[25];
      initial_insufficient_material <= flags[24];
      initial_board_check <= flags[23];
      am_move_count <= counts[31 -: MOVE_BITS];
      am_half_move <= counts[23 -: HALF_BITS];
      am_eval <= eval_a[31 -: EVAL_BITS];
      initial_eval <= eval_b[31 -: EVAL_BITS];
   endtask

   task automatic read_reg(reg_index_t idx, output axi_data_t data);
      int hold;
      axi_data_t first;
      hold = rand_below(4);
      shuffle_engine();
      @(posedge clk);
      araddr <= axi_addr_t'({idx, 2'b00});
      arvalid <= 1'b1;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      first = rdata;
      check_resp(rresp, RESP_OKAY, "rresp");
      repeat (hold)
      begin
         @(negedge clk);
         expect_true(rvalid, "rvalid dropped while rready was low");
         check_data(rdata, first, "rdata while stalled");
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
      @(negedge clk);
      expect_true(!rvalid && arready, "read channel not idle after the data was taken");
      data = first;
   endtask

   task automatic check_read(reg_index_t idx);
      axi_data_t got;
      read_reg(idx, got);
      check_data(got, expected_read(idx), $sformatf("rdata of register %0d", idx));
   endtask

   // Second write arrives while the first response is held back
   task automatic stalled_pair();
      reg_index_t idx_a;
      reg_index_t idx_b;
      axi_data_t data_a;
      axi_data_t data_b;
      idx_a = write_index(rand_below(13));
      data_a = rand32();
      idx_b = write_index(rand_below(13));
      data_b = rand32();
      put_write(idx_a, data_a, 4'hf);
      apply_write(idx_a, data_a, 4'hf);
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      put_write(idx_b, data_b, 4'hf);
      @(negedge clk);
      expect_true(!awready && !wready, "slots still ready with both full and bvalid high");
      check_outputs();
      take_response();
      apply_write(idx_b, data_b, 4'hf);
      take_response();
      check_outputs();
   endtask

   initial
   begin
      reg_index_t idx;
      axi_data_t data;
      axi_strb_t strb;
      int op;
      reset = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      am_idle = 1'b0;
      am_moves_ready = 1'b0;
      am_move_ready = 1'b0;
      am_move_count = '0;
      am_eval = '0;
      am_half_move = '0;
      initial_mate = 1'b0;
      initial_stalemate = 1'b0;
      initial_thrice_rep = 1'b0;
      initial_fifty_move = 1'b0;
      initial_insufficient_material = 1'b0;
      initial_board_check = 1'b0;
      initial_eval = '0;
      clear_image();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      expect_true(awready && wready && arready, "a ready signal is low after reset");
      expect_true(!bvalid && !rvalid, "a valid signal is high after reset");
      check_outputs();
      for (int i = 0; i < 13; i++)
         check_read(write_index(i));
      for (int i = 0; i < 13; i++)
      begin
         data = rand32();
         write_reg(write_index(i), data, 4'hf);
         check_read(write_index(i));
      end
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         op = rand_below(8);
         if (op < 5)
         begin
            idx = (op == 4) ? pick_unknown() : write_index(rand_below(13));
            data = rand32();
            strb = axi_strb_t'(rand_below(16));
            write_reg(idx, data, strb);
         end
         else if (op == 5)
            check_read(write_index(rand_below(13)));
         else if (op == 6)
            check_read(pick_unknown());
         else
            check_read(status_index(rand_below(5)));
      end
      for (int i = 0; i < 20; i++)
         check_read(status_index(i % 5));
      for (int i = 0; i < NUM_STALLS; i++)
         stalled_pair();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+verification
rtl/vchess_ctrl_pkg.sv
rtl/reg_write_if.sv
rtl/axi_channel_slot.sv
rtl/axi_write_commit.sv
rtl/control_reg_bank.sv
rtl/status_read_port.sv
rtl/ctrl_regs_top.sv
verification/tb_ctrl_regs.sv

// ==== Makefile ====
# Verilator flow for the control register block

TOP       ?= tb_ctrl_regs
SOURCES   ?= sources.f
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) into $(LOG) and check the result"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP SOURCES LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(SOURCES)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Test passed: $(TOP)"; \
	else \
		echo "Test failed: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
